//--- headFifo.f
+incdir+hw
hw/fifoDataPkg.sv
hw/fifoStatusPkg.sv
hw/fifoWriteStage.sv
hw/fifoOccupancy.sv
hw/fifoHeadStage.sv
hw/headFifo.sv
dv/headFifo_asserts.sv
dv/headFifo_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module headFifo_tb \
		-Mdir obj_dir -f headFifo.f
	./obj_dir/VheadFifo_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || { echo "simulation failed"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- dv/headFifo_tb.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module headFifo_tb;

   logic                     clkin;
   logic                     reset_n;
   logic                     syncClear;
   fifoDataPkg::writeReq     wrReq;
   logic                     rdEn;
   fifoDataPkg::fifoWord     dataOut;
   fifoStatusPkg::fifoStatus status;

   // expected contents, oldest word at index 0
   fifoDataPkg::fifoWord modelQ [$];
   integer               seed;
   int                   mismatchCount;
   int                   failureCount;

   headFifo u_headFifo (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrReq     (wrReq),
      .rdEn      (rdEn),
      .dataOut   (dataOut),
      .status    (status)
   );

   always #4 clkin = ~clkin;

   // flags expected for a given number of held words
   function automatic fifoStatusPkg::fifoStatus expectStatus(input int n);
      fifoStatusPkg::fifoStatus s;
      s.empty       = (n == 0);
      s.almostEmpty = (n <= `FIFO_AE_LEVEL);
      s.almostFull  = (n > `FIFO_AF_LEVEL);
      s.full        = (n == `FIFO_DEPTH);
      return s;
   endfunction

   function automatic fifoDataPkg::fifoWord patternWord(input int i);
      return fifoDataPkg::fifoWord'(32'hc0de_0000 + i);
   endfunction

   task automatic checkWord(input string name, input fifoDataPkg::fifoWord actual,
                            input fifoDataPkg::fifoWord expected);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
         mismatchCount++;
      end
   endtask

   task automatic checkStatus(input string name, input fifoStatusPkg::fifoStatus actual,
                              input fifoStatusPkg::fifoStatus expected);
      if (actual !== expected) begin
         $display("mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
         mismatchCount++;
      end
   endtask

   // one ns after the next rising edge
   task automatic nextDriveSlot();
      @(posedge clkin);
      #1;
   endtask

   task automatic applyInputs(input bit wr, input fifoDataPkg::fifoWord data, input bit rd);
      wrReq.wrEn = wr;
      wrReq.data = data;
      rdEn       = rd;
   endtask

   task automatic failOnTimeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      failureCount++;
      $display("mismatches: %0d, other failures: %0d", mismatchCount, failureCount);
      $display("ERRORS FOUND");
      $finish;
   endtask

   task automatic waitNotEmpty(input int limit, input string what);
      int cycles;
      cycles = 0;
      while (status.empty && cycles < limit) begin
         nextDriveSlot();
         cycles++;
      end
      if (status.empty) begin
         failOnTimeout(what);
      end
   endtask

   // model follows each edge, outputs compared once settled
   initial begin
      forever begin
         @(posedge clkin);
         if (!reset_n || syncClear) begin
            modelQ.delete();
         end else begin
            if (rdEn && modelQ.size() > 0) begin
               void'(modelQ.pop_front());
            end
            if (wrReq.wrEn) begin
               modelQ.push_back(wrReq.data);
            end
         end
         #2;
         if (modelQ.size() > 0) begin
            checkWord("dataOut", dataOut, modelQ[0]);
         end
         checkStatus("status", status, expectStatus(modelQ.size()));
         // stimulus for the coming edge must respect the flags
         if (reset_n && wrReq.wrEn && status.full) begin
            $display("error at %0t: write driven while the FIFO is full", $time);
            failureCount++;
         end
         if (reset_n && rdEn && status.empty) begin
            $display("error at %0t: read driven while the FIFO is empty", $time);
            failureCount++;
         end
      end
   end

   initial begin
      fifoDataPkg::fifoWord word;
      logic [31:0]          randWord;
      int                   cycles;
      bit                   doWrite;
      bit                   doRead;

      clkin         = 1'b0;
      reset_n       = 1'b0;
      syncClear     = 1'b0;
      wrReq         = '0;
      rdEn          = 1'b0;
      seed          = 32'hb9b6_bb33;
      mismatchCount = 0;
      failureCount  = 0;

      repeat (8) @(posedge clkin);
      #1;
      reset_n = 1'b1;
      nextDriveSlot();
      checkStatus("status", status, expectStatus(0));

      // single word into an empty FIFO
      word = patternWord(0);
      applyInputs(1'b1, word, 1'b0);
      nextDriveSlot();
      applyInputs(1'b0, '0, 1'b0);
      waitNotEmpty(4, "single write never cleared empty");
      checkWord("dataOut", dataOut, word);
      applyInputs(1'b0, '0, 1'b1);
      nextDriveSlot();
      applyInputs(1'b0, '0, 1'b0);

      // fill with writes only
      cycles = 0;
      while (!status.full && cycles < `FIFO_DEPTH + 4) begin
         applyInputs(1'b1, patternWord(cycles + 1), 1'b0);
         nextDriveSlot();
         cycles++;
      end
      applyInputs(1'b0, '0, 1'b0);
      if (!status.full) begin
         failOnTimeout("FIFO never reported full while filling");
      end

      // drain with reads only
      cycles = 0;
      while (!status.empty && cycles < `FIFO_DEPTH + 4) begin
         applyInputs(1'b0, '0, 1'b1);
         nextDriveSlot();
         cycles++;
      end
      applyInputs(1'b0, '0, 1'b0);
      if (!status.empty) begin
         failOnTimeout("FIFO never reported empty while draining");
      end

      // write and read together with one word held
      applyInputs(1'b1, patternWord(100), 1'b0);
      nextDriveSlot();
      applyInputs(1'b1, patternWord(101), 1'b1);
      nextDriveSlot();
      applyInputs(1'b0, '0, 1'b1);
      nextDriveSlot();

      // random traffic, write heavy first and read heavy after
      for (int i = 0; i < 300; i++) begin
         randWord = $random(seed);
         if (i < 150) begin
            doWrite = (randWord[1:0] != 2'b00) && !status.full;
            doRead  = randWord[2] && !status.empty;
         end else begin
            doWrite = randWord[0] && !status.full;
            doRead  = (randWord[2:1] != 2'b00) && !status.empty;
         end
         randWord = $random(seed);
         applyInputs(doWrite, randWord, doRead);
         nextDriveSlot();
      end

      // clear in mid-stream
      for (int i = 0; i < 3; i++) begin
         applyInputs(!status.full, patternWord(200 + i), 1'b0);
         nextDriveSlot();
      end
      applyInputs(1'b0, '0, 1'b0);
      syncClear = 1'b1;
      nextDriveSlot();
      syncClear = 1'b0;
      checkStatus("status", status, expectStatus(0));
      word = patternWord(300);
      applyInputs(1'b1, word, 1'b0);
      nextDriveSlot();
      applyInputs(1'b0, '0, 1'b0);
      waitNotEmpty(4, "write after clear never cleared empty");
      checkWord("dataOut", dataOut, word);

      nextDriveSlot();
      nextDriveSlot();
      $display("mismatches: %0d, other failures: %0d", mismatchCount, failureCount);
      if (mismatchCount == 0 && failureCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- dv/headFifo_asserts.sv
`timescale 1ns/1ps

module headFifo_asserts (
   input logic                     clkin,
   input logic                     reset_n,
   input logic                     syncClear,
   input fifoDataPkg::writeReq     wrReq,
   input logic                     rdEn,
   input fifoStatusPkg::fifoStatus status
);

   // a write at full would land on the slot behind the head
   noWriteWhenFull: assert property (
      @(posedge clkin) disable iff (!reset_n)
      (wrReq.wrEn && !syncClear) |-> !status.full
   ) else $error("write issued while the FIFO reported full");

   // no pop without a word in the head
   noReadWhenEmpty: assert property (
      @(posedge clkin) disable iff (!reset_n)
      (rdEn && !syncClear) |-> !status.empty
   ) else $error("read issued while the FIFO reported empty");

   flagsExclusive: assert property (
      @(posedge clkin) disable iff (!reset_n)
      !(status.empty && status.full)
   ) else $error("empty and full flags both high");

endmodule

bind headFifo headFifo_asserts u_asserts (
   .clkin     (clkin),
   .reset_n   (reset_n),
   .syncClear (syncClear),
   .wrReq     (wrReq),
   .rdEn      (rdEn),
   .status    (status)
);

//--- hw/headFifo.sv
`timescale 1ns/1ps

module headFifo (
   input  logic                     clkin,
   input  logic                     reset_n,
   input  logic                     syncClear,
   input  fifoDataPkg::writeReq     wrReq,
   input  logic                     rdEn,
   output fifoDataPkg::fifoWord     dataOut,
   output fifoStatusPkg::fifoStatus status
);

   fifoDataPkg::fifoCount count;
   fifoDataPkg::fifoPtr   rdPtr;
   fifoDataPkg::fifoWord  memWord;

   // storage and write pointer
   fifoWriteStage u_writeStage (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrReq     (wrReq),
      .rdPtr     (rdPtr),
      .memWord   (memWord)
   );

   // counter and registered flags
   fifoOccupancy u_occupancy (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrReq     (wrReq),
      .rdEn      (rdEn),
      .count     (count),
      .status    (status)
   );

   // head register and read pointer
   fifoHeadStage u_headStage (
      .clkin     (clkin),
      .reset_n   (reset_n),
      .syncClear (syncClear),
      .wrReq     (wrReq),
      .rdEn      (rdEn),
      .count     (count),
      .memWord   (memWord),
      .rdPtr     (rdPtr),
      .dataOut   (dataOut)
   );

endmodule

//--- hw/fifoHeadStage.sv
`timescale 1ns/1ps

module fifoHeadStage (
   input  logic                  clkin,
   input  logic                  reset_n,
   input  logic                  syncClear,
   input  fifoDataPkg::writeReq  wrReq,
   input  logic                  rdEn,
   input  fifoDataPkg::fifoCount count,
   input  fifoDataPkg::fifoWord  memWord,
   output fifoDataPkg::fifoPtr   rdPtr,
   output fifoDataPkg::fifoWord  dataOut
);

   localparam fifoDataPkg::fifoCount oneWord = fifoDataPkg::fifoCount'(1);

   fifoDataPkg::fifoWord headWord;

   logic countIsZero;
   logic countIsOne;
   logic loadIncoming;
   logic loadMemory;
   logic advance;

   assign countIsZero = (count == '0);
   assign countIsOne  = (count == oneWord);

   // bypass the array when nothing older is waiting behind the head
   assign loadIncoming = wrReq.wrEn && (countIsZero || (countIsOne && rdEn));

   // pop refills from the array
   assign loadMemory = rdEn && !loadIncoming;

   // a word moves into the head, so the array slot behind it is consumed
   assign advance = loadIncoming || (rdEn && (count > oneWord));

   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         rdPtr <= '0;
      end else if (syncClear) begin
         rdPtr <= '0;
      end else if (advance) begin
         rdPtr <= rdPtr + 1'b1;
      end
   end

   // head register
   // a pop of the last word with no write leaves a stale value here,
   // which empty already flags
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         headWord <= '0;
      end else if (syncClear) begin
         headWord <= '0;
      end else if (loadIncoming) begin
         headWord <= wrReq.data;
      end else if (loadMemory) begin
         headWord <= memWord;
      end
   end

   assign dataOut = headWord;

endmodule

//--- hw/fifoOccupancy.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifoOccupancy (
   input  logic                    clkin,
   input  logic                    reset_n,
   input  logic                    syncClear,
   input  fifoDataPkg::writeReq    wrReq,
   input  logic                    rdEn,
   output fifoDataPkg::fifoCount   count,
   output fifoStatusPkg::fifoStatus status
);

   // thresholds sized to the counter
   localparam fifoDataPkg::fifoCount depthCount = fifoDataPkg::fifoCount'(`FIFO_DEPTH);
   localparam fifoDataPkg::fifoCount aeLevel    = fifoDataPkg::fifoCount'(`FIFO_AE_LEVEL);
   localparam fifoDataPkg::fifoCount afLevel    = fifoDataPkg::fifoCount'(`FIFO_AF_LEVEL);

   fifoDataPkg::fifoCount nextCount;

   // flag decode of one count value
   function automatic fifoStatusPkg::fifoStatus flagsFor(
      input fifoDataPkg::fifoCount c
   );
      fifoStatusPkg::fifoStatus s;
      s.empty       = (c == '0);
      s.almostEmpty = (c <= aeLevel);
      s.almostFull  = (c > afLevel);
      s.full        = (c == depthCount);
      return s;
   endfunction

   // next occupancy
   // head word counts as held
   always_comb begin
      nextCount = count;
      if (syncClear) begin
         nextCount = '0;
      end else if (wrReq.wrEn && !rdEn) begin
         nextCount = count + 1'b1;
      end else if (!wrReq.wrEn && rdEn) begin
         nextCount = count - 1'b1;
      end
   end

   // counter and flags move on the same edge
   // flags decode the value being stored, so they track the last accesses
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         count  <= '0;
         status <= fifoStatusPkg::statusIdle;
      end else begin
         count  <= nextCount;
         status <= flagsFor(nextCount);
      end
   end

endmodule

//--- hw/fifoWriteStage.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifoWriteStage (
   input  logic                 clkin,
   input  logic                 reset_n,
   input  logic                 syncClear,
   input  fifoDataPkg::writeReq wrReq,
   input  fifoDataPkg::fifoPtr  rdPtr,
   output fifoDataPkg::fifoWord memWord
);

   // distributed storage, one entry per slot
   fifoDataPkg::fifoWord memArray [`FIFO_DEPTH];

   fifoDataPkg::fifoPtr wrPtr;

   // write pointer
   // wraps on its own since the depth is a power of two
   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         wrPtr <= '0;
      end else if (syncClear) begin
         wrPtr <= '0;
      end else if (wrReq.wrEn) begin
         wrPtr <= wrPtr + 1'b1;
      end
   end

   // storage update on the write edge
   always_ff @(posedge clkin) begin
      if (wrReq.wrEn) begin
         memArray[wrPtr] <= wrReq.data;
      end
   end

   // combinational read port for the head stage
   // rdPtr points one past the word held in the head
   assign memWord = memArray[rdPtr];

endmodule

//--- hw/fifoStatusPkg.sv
package fifoStatusPkg;

   // registered flags seen by both sides
   typedef struct packed {
      logic empty;
      logic almostEmpty;
      logic almostFull;
      logic full;
   } fifoStatus;

   // flags of a FIFO holding nothing
   localparam fifoStatus statusIdle = '{
      empty:       1'b1,
      almostEmpty: 1'b1,
      almostFull:  1'b0,
      full:        1'b0
   };

endpackage

//--- hw/fifoDataPkg.sv
`include "fifo_defs.svh"

package fifoDataPkg;

   // one payload word as stored and presented
   typedef logic [`FIFO_WIDTH-1:0] fifoWord;

   // index into the storage array, wraps at the depth
   typedef logic [`FIFO_PTR_W-1:0] fifoPtr;

   // occupancy, one bit wider so the full depth fits
   typedef logic [`FIFO_PTR_W:0] fifoCount;

   // write side request
   typedef struct packed {
      logic    wrEn;
      fifoWord data;
   } writeReq;

endpackage

//--- hw/fifo_defs.svh
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// width of one stored word
`define FIFO_WIDTH 32

// number of storage entries, power of two only
`define FIFO_DEPTH 16

// index width into the storage array
`define FIFO_PTR_W $clog2(`FIFO_DEPTH)

// almost empty while the count is at or below a quarter of the depth
`define FIFO_AE_LEVEL (`FIFO_DEPTH >> 2)

// almost full once the count climbs above two short of the depth
`define FIFO_AF_LEVEL (`FIFO_DEPTH - 2)

`endif
